// ==== dv/lenet_mac_tb.sv ====
`default_nettype none

module lenet_mac_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_MAX = 200;

    logic                                 clk;
    logic                                 rst_n;
    logic [lenet_mac_pkg::AXI_ADDR_W-1:0] awaddr;
    logic                                 awvalid;
    logic                                 awready;
    logic [lenet_mac_pkg::AXI_DATA_W-1:0] wdata;
    logic                                 wvalid;
    logic                                 wready;
    logic [1:0]                           bresp;
    logic                                 bvalid;
    logic                                 bready;
    logic [lenet_mac_pkg::AXI_ADDR_W-1:0] araddr;
    logic                                 arvalid;
    logic                                 arready;
    logic [lenet_mac_pkg::AXI_DATA_W-1:0] rdata;
    logic [1:0]                           rresp;
    logic                                 rvalid;
    logic                                 rready;

    // reference copies of both operand memories.
    logic [lenet_mac_pkg::DATA_W-1:0] w_model [lenet_mac_pkg::TAPS_MAX];
    logic [lenet_mac_pkg::DATA_W-1:0] a_model [lenet_mac_pkg::TAPS_MAX];

    int          len;
    int          shift;
    logic [31:0] rd_val;
    logic [1:0]  resp;

    lenet_mac_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #10 clk = ~clk;

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic [lenet_mac_pkg::AXI_ADDR_W-1:0] tap_addr(
        input logic [lenet_mac_pkg::AXI_ADDR_W-1:0] base, input int idx);
        return base + lenet_mac_pkg::AXI_ADDR_W'(idx * 4);
    endfunction

    // ##########################################################
    // AXI4-Lite bus tasks
    // ##########################################################
    task automatic axi_write(input logic [lenet_mac_pkg::AXI_ADDR_W-1:0] addr,
                             input logic [31:0] data_in, output logic [1:0] resp_out);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data_in;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) timeout_abort("awready and wready");
        end
        // handshake completes on the edge in between.
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) timeout_abort("bvalid");
        end
        resp_out = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [lenet_mac_pkg::AXI_ADDR_W-1:0] addr,
                            output logic [31:0] data_out, output logic [1:0] resp_out);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) timeout_abort("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) timeout_abort("rvalid");
        end
        data_out = rdata;
        resp_out = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_ok(input logic [lenet_mac_pkg::AXI_ADDR_W-1:0] addr,
                            input logic [31:0] data_in, input string what);
        logic [1:0] r;
        axi_write(addr, data_in, r);
        check_eq({what, " write response"}, 32'(r), 32'(lenet_mac_pkg::RESP_OKAY));
    endtask

    task automatic read_ok(input logic [lenet_mac_pkg::AXI_ADDR_W-1:0] addr,
                           input string what, output logic [31:0] data_out);
        logic [1:0] r;
        axi_read(addr, data_out, r);
        check_eq({what, " read response"}, 32'(r), 32'(lenet_mac_pkg::RESP_OKAY));
    endtask

    // ##########################################################
    // run control and reference model
    // ##########################################################
    task automatic load_operands(input int n_taps);
        for (int i = 0; i < n_taps; i++) begin
            write_ok(tap_addr(lenet_mac_pkg::WEIGHT_BASE, i), 32'(w_model[i]), "weight");
            write_ok(tap_addr(lenet_mac_pkg::ACT_BASE, i), 32'(a_model[i]), "activation");
        end
    endtask

    task automatic start_run(input int n_taps, input int sh, input logic exact);
        write_ok(lenet_mac_pkg::REG_LEN, 32'(n_taps), "len");
        write_ok(lenet_mac_pkg::REG_SHIFT, 32'(sh), "shift");
        write_ok(lenet_mac_pkg::REG_CTRL, {30'd0, exact, 1'b1}, "start");
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int n;
        st = '0;
        n = 0;
        while (!st[1]) begin
            read_ok(lenet_mac_pkg::REG_STATUS, "status poll", st);
            n++;
            if (n > WAIT_MAX) timeout_abort("done in the status register");
        end
        check_eq("busy after done", 32'(st[0]), 32'd0);
    endtask

    task automatic check_results(input int n_taps, input int sh);
        logic [31:0] exp_acc;
        logic [31:0] exp_res;
        logic [31:0] got;
        exp_acc = '0;
        for (int i = 0; i < n_taps; i++) begin
            exp_acc = exp_acc + 32'(w_model[i]) * 32'(a_model[i]);
        end
        exp_res = exp_acc >> sh;
        if (exp_res > 32'd255) begin
            exp_res = 32'd255;
        end
        read_ok(lenet_mac_pkg::REG_ACC, "acc", got);
        check_eq("raw accumulator", got, exp_acc);
        read_ok(lenet_mac_pkg::REG_RESULT, "result", got);
        check_eq("scaled result", got, exp_res);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(32'h4cf1de3e));
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        read_ok(lenet_mac_pkg::REG_STATUS, "status after reset", rd_val);
        check_eq("status after reset", rd_val, 32'd0);

        // exact mode, fully random operands.
        for (int r = 0; r < 20; r++) begin
            len   = 1 + int'($urandom % 32);
            shift = int'($urandom % 16);
            for (int i = 0; i < len; i++) begin
                w_model[i] = 8'($urandom);
                a_model[i] = 8'($urandom);
            end
            load_operands(len);
            start_run(len, shift, 1'b1);
            wait_done();
            check_results(len, shift);
        end

        // approximate mode, weights only in bits 6 and 7.
        for (int r = 0; r < 10; r++) begin
            len   = 1 + int'($urandom % 32);
            shift = int'($urandom % 16);
            for (int i = 0; i < len; i++) begin
                w_model[i] = 8'(($urandom % 4) * 64);
                a_model[i] = 8'($urandom);
            end
            load_operands(len);
            start_run(len, shift, 1'b0);
            wait_done();
            check_results(len, shift);
        end

        // saturation with full-scale operands.
        for (int i = 0; i < lenet_mac_pkg::TAPS_MAX; i++) begin
            w_model[i] = 8'hff;
            a_model[i] = 8'hff;
        end
        load_operands(lenet_mac_pkg::TAPS_MAX);
        start_run(lenet_mac_pkg::TAPS_MAX, 0, 1'b1);
        wait_done();
        check_results(lenet_mac_pkg::TAPS_MAX, 0);
        read_ok(lenet_mac_pkg::REG_RESULT, "result", rd_val);
        check_eq("saturated result", rd_val, 32'd255);

        // unmapped offset and operand read-back.
        axi_write(9'h020, 32'h1234_5678, resp);
        check_eq("unmapped write response", 32'(resp), 32'(lenet_mac_pkg::RESP_SLVERR));
        axi_read(9'h020, rd_val, resp);
        check_eq("unmapped read response", 32'(resp), 32'(lenet_mac_pkg::RESP_SLVERR));
        check_eq("unmapped read data", rd_val, 32'd0);
        axi_read(lenet_mac_pkg::WEIGHT_BASE, rd_val, resp);
        check_eq("weight read-back response", 32'(resp), 32'(lenet_mac_pkg::RESP_SLVERR));

        // done holds until the next start clears it.
        read_ok(lenet_mac_pkg::REG_STATUS, "status after run", rd_val);
        check_eq("status after run", rd_val, 32'd2);
        start_run(lenet_mac_pkg::TAPS_MAX, 3, 1'b1);
        read_ok(lenet_mac_pkg::REG_STATUS, "status after start", rd_val);
        check_eq("status after start", rd_val, 32'd1);
        wait_done();
        check_results(lenet_mac_pkg::TAPS_MAX, 3);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lenet_mac.f ====
logic/lenet_mac_pkg.sv
logic/approx_mult_8x8.sv
logic/operand_ram.sv
logic/mac_accum.sv
logic/mac_ctrl.sv
logic/lenet_mac_top.sv
dv/lenet_mac_tb.sv

// ==== logic/approx_mult_8x8.sv ====
`default_nettype none

module approx_mult_8x8 (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [lenet_mac_pkg::DATA_W-1:0] x,
    input  wire  [lenet_mac_pkg::DATA_W-1:0] y,
    input  wire                              exact_mode,
    output logic [lenet_mac_pkg::PROD_W-1:0] prod
);

    wire [lenet_mac_pkg::DATA_W-1:0] pp [lenet_mac_pkg::DATA_W];

    wire [lenet_mac_pkg::PROD_W-1:0] row6;
    wire [lenet_mac_pkg::PROD_W-1:0] row7;
    wire [lenet_mac_pkg::PROD_W-1:0] np1;
    wire [lenet_mac_pkg::PROD_W-1:0] np2;
    wire [lenet_mac_pkg::PROD_W-1:0] np3;
    wire [lenet_mac_pkg::PROD_W-1:0] np4;
    wire [lenet_mac_pkg::PROD_W-1:0] np5;
    wire [lenet_mac_pkg::PROD_W-1:0] np6;
    wire [lenet_mac_pkg::PROD_W-1:0] approx;
    wire [lenet_mac_pkg::PROD_W-1:0] exact;

    // one partial-product row per weight bit.
    for (genvar i = 0; i < lenet_mac_pkg::DATA_W; i++) begin : g_pp
        assign pp[i] = y & {lenet_mac_pkg::DATA_W{x[i]}};
    end

    // ##########################################################
    // rows 7 and 8 kept exact
    // ##########################################################
    assign row6 = {2'b00, pp[6], 6'b000000};
    assign row7 = {1'b0, pp[7], 7'b0000000};

    // ##########################################################
    // rows 1 to 6 folded into six sparse vectors
    // ##########################################################
    assign np1 = {3'b000, pp[5][7], pp[4][6] & pp[5][5], pp[2][7] & pp[3][6],
                  pp[2][6] & pp[3][5], pp[1][7], pp[0][6] | pp[1][5],
                  pp[4][1] ^ pp[5][0], pp[2][2] & pp[3][1], pp[0][4] | pp[1][3],
                  4'b0000};

    assign np2 = {4'b0000, pp[4][7] & pp[5][6], pp[3][7], pp[2][7] | pp[3][6],
                  pp[2][6] ^ pp[3][5], pp[0][7] ^ pp[1][6], 2'b00, pp[4][0],
                  4'b0000};

    assign np3 = {4'b0000, pp[4][7] ^ pp[5][6], pp[4][6] ^ pp[5][5],
                  pp[4][4] & pp[5][3], 1'b0, pp[2][5] | pp[3][4], 7'b0000000};

    // only bits 7 and 9 survive in the last three.
    assign np4 = {6'b000000, pp[4][4] | pp[5][3], 1'b0, pp[4][2] | pp[5][1],
                  7'b0000000};
    assign np5 = {6'b000000, pp[4][5] & pp[5][4], 9'b000000000};
    assign np6 = {6'b000000, pp[4][5] | pp[5][4], 9'b000000000};

    assign approx = row6 + row7 + np1 + np2 + np3 + np4 + np5 + np6;
    assign exact  = x * y;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod <= '0;
        end else begin
            prod <= exact_mode ? exact : approx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/lenet_mac_pkg.sv ====
`default_nettype none

package lenet_mac_pkg;

    // ##########################################################
    // datapath widths
    // ##########################################################
    localparam int DATA_W   = 8;
    localparam int PROD_W   = 16;
    localparam int TAPS_MAX = 32;
    localparam int ADDR_W   = 5;
    localparam int LEN_W    = 6;
    localparam int SHIFT_W  = 4;
    localparam int ACC_W    = 24;

    // 32 taps at 4 bytes each for two memories need a 9-bit window.
    localparam int AXI_ADDR_W = 9;
    localparam int AXI_DATA_W = 32;

    // ##########################################################
    // register map
    // ##########################################################
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL    = 9'h000;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS  = 9'h004;
    localparam logic [AXI_ADDR_W-1:0] REG_LEN     = 9'h008;
    localparam logic [AXI_ADDR_W-1:0] REG_SHIFT   = 9'h00C;
    localparam logic [AXI_ADDR_W-1:0] REG_RESULT  = 9'h010;
    localparam logic [AXI_ADDR_W-1:0] REG_ACC     = 9'h014;
    localparam logic [AXI_ADDR_W-1:0] WEIGHT_BASE = 9'h040;
    localparam logic [AXI_ADDR_W-1:0] ACT_BASE    = 9'h100;
    localparam logic [AXI_ADDR_W-1:0] OPER_SPAN   = 9'h080;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== logic/lenet_mac_top.sv ====
`default_nettype none

module lenet_mac_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [lenet_mac_pkg::AXI_ADDR_W-1:0] awaddr,
    input  wire                                  awvalid,
    output logic                                 awready,
    input  wire  [lenet_mac_pkg::AXI_DATA_W-1:0] wdata,
    input  wire                                  wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  wire                                  bready,
    input  wire  [lenet_mac_pkg::AXI_ADDR_W-1:0] araddr,
    input  wire                                  arvalid,
    output logic                                 arready,
    output logic [lenet_mac_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  wire                                  rready
);

    logic                                w_wr_en;
    logic                                a_wr_en;
    logic [lenet_mac_pkg::ADDR_W-1:0]    wr_addr;
    logic [lenet_mac_pkg::DATA_W-1:0]    wr_data;
    logic [lenet_mac_pkg::ADDR_W-1:0]    rd_addr;
    logic [lenet_mac_pkg::DATA_W-1:0]    weight;
    logic [lenet_mac_pkg::DATA_W-1:0]    act;
    logic [lenet_mac_pkg::PROD_W-1:0]    prod;
    logic                                tap_valid;
    logic                                last_tap;
    logic                                acc_clear;
    logic                                exact_mode;
    logic [lenet_mac_pkg::SHIFT_W-1:0]   shift;
    logic [lenet_mac_pkg::ACC_W-1:0]     acc;
    logic [lenet_mac_pkg::DATA_W-1:0]    result;
    logic                                acc_done;

    mac_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .acc_done   (acc_done),
        .result     (result),
        .acc        (acc),
        .w_wr_en    (w_wr_en),
        .a_wr_en    (a_wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .tap_valid  (tap_valid),
        .last_tap   (last_tap),
        .acc_clear  (acc_clear),
        .exact_mode (exact_mode),
        .shift      (shift)
    );

    operand_ram u_weight_ram (
        .clk     (clk),
        .wr_en   (w_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (weight)
    );

    operand_ram u_act_ram (
        .clk     (clk),
        .wr_en   (a_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (act)
    );

    // weight selects the partial-product rows.
    approx_mult_8x8 u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (weight),
        .y          (act),
        .exact_mode (exact_mode),
        .prod       (prod)
    );

    mac_accum u_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod       (prod),
        .prod_valid (tap_valid),
        .prod_last  (last_tap),
        .acc_clear  (acc_clear),
        .shift      (shift),
        .acc        (acc),
        .result     (result),
        .acc_done   (acc_done)
    );

endmodule

`default_nettype wire

// ==== logic/mac_accum.sv ====
`default_nettype none

module mac_accum (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [lenet_mac_pkg::PROD_W-1:0]  prod,
    input  wire                               prod_valid,
    input  wire                               prod_last,
    input  wire                               acc_clear,
    input  wire  [lenet_mac_pkg::SHIFT_W-1:0] shift,
    output logic [lenet_mac_pkg::ACC_W-1:0]   acc,
    output logic [lenet_mac_pkg::DATA_W-1:0]  result,
    output logic                              acc_done
);

    logic [lenet_mac_pkg::ACC_W-1:0] shifted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            acc_done <= 1'b0;
        end else begin
            acc_done <= prod_valid & prod_last;
            if (acc_clear) begin
                acc <= '0;
            end else if (prod_valid) begin
                acc <= acc + lenet_mac_pkg::ACC_W'(prod);
            end
        end
    end

    // scale down, then clamp to the 8-bit range.
    always_comb begin
        shifted = acc >> shift;
        if (|shifted[lenet_mac_pkg::ACC_W-1:lenet_mac_pkg::DATA_W]) begin
            result = '1;
        end else begin
            result = shifted[lenet_mac_pkg::DATA_W-1:0];
        end
    end

    // the clear pulse always precedes the first product of a run.
    a_clear_vs_add: assert property (@(posedge clk) disable iff (!rst_n)
        !(acc_clear && prod_valid));

endmodule

`default_nettype wire

// ==== logic/mac_ctrl.sv ====
`default_nettype none

module mac_ctrl (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [lenet_mac_pkg::AXI_ADDR_W-1:0] awaddr,
    input  wire                                  awvalid,
    output logic                                 awready,
    input  wire  [lenet_mac_pkg::AXI_DATA_W-1:0] wdata,
    input  wire                                  wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  wire                                  bready,
    input  wire  [lenet_mac_pkg::AXI_ADDR_W-1:0] araddr,
    input  wire                                  arvalid,
    output logic                                 arready,
    output logic [lenet_mac_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  wire                                  rready,
    input  wire                                  acc_done,
    input  wire  [lenet_mac_pkg::DATA_W-1:0]     result,
    input  wire  [lenet_mac_pkg::ACC_W-1:0]      acc,
    output logic                                 w_wr_en,
    output logic                                 a_wr_en,
    output logic [lenet_mac_pkg::ADDR_W-1:0]     wr_addr,
    output logic [lenet_mac_pkg::DATA_W-1:0]     wr_data,
    output logic [lenet_mac_pkg::ADDR_W-1:0]     rd_addr,
    output logic                                 tap_valid,
    output logic                                 last_tap,
    output logic                                 acc_clear,
    output logic                                 exact_mode,
    output logic [lenet_mac_pkg::SHIFT_W-1:0]    shift
);

    logic                                 wr_ready;
    logic                                 wr_hs;
    logic                                 rd_hs;
    logic                                 w_hit;
    logic                                 a_hit;
    logic                                 start_go;
    logic                                 busy;
    logic                                 done;
    logic                                 issue;
    logic                                 issue_last;
    logic [lenet_mac_pkg::LEN_W-1:0]      len;
    logic [lenet_mac_pkg::ADDR_W-1:0]     last_idx;
    logic [lenet_mac_pkg::AXI_ADDR_W-1:0] w_off;
    logic [lenet_mac_pkg::AXI_ADDR_W-1:0] a_off;
    logic [lenet_mac_pkg::AXI_DATA_W-1:0] rd_mux;
    logic [1:0]                           valid_pipe;
    logic [1:0]                           last_pipe;

    function automatic logic reg_hit(input logic [lenet_mac_pkg::AXI_ADDR_W-1:0] addr);
        return addr inside {lenet_mac_pkg::REG_CTRL, lenet_mac_pkg::REG_STATUS,
                            lenet_mac_pkg::REG_LEN, lenet_mac_pkg::REG_SHIFT,
                            lenet_mac_pkg::REG_RESULT, lenet_mac_pkg::REG_ACC};
    endfunction

    assign awready = wr_ready;
    assign wready  = wr_ready;
    assign wr_hs   = wr_ready & awvalid & wvalid;
    assign rd_hs   = arready & arvalid;

    // operand windows, word aligned.
    assign w_off = awaddr - lenet_mac_pkg::WEIGHT_BASE;
    assign a_off = awaddr - lenet_mac_pkg::ACT_BASE;
    assign w_hit = (w_off < lenet_mac_pkg::OPER_SPAN) && (w_off[1:0] == 2'b00);
    assign a_hit = (a_off < lenet_mac_pkg::OPER_SPAN) && (a_off[1:0] == 2'b00);

    // start while busy is acked but dropped.
    assign start_go   = wr_hs && (awaddr == lenet_mac_pkg::REG_CTRL) && wdata[0] && !busy;
    assign last_idx   = len[lenet_mac_pkg::ADDR_W-1:0] - 1'b1;
    assign issue_last = issue && (rd_addr == last_idx);

    // ##########################################################
    // write channel and register file
    // ##########################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ready   <= 1'b0;
            bvalid     <= 1'b0;
            w_wr_en    <= 1'b0;
            a_wr_en    <= 1'b0;
            exact_mode <= 1'b0;
            len        <= lenet_mac_pkg::LEN_W'(1);
            shift      <= '0;
        end else begin
            wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;
            w_wr_en  <= wr_hs && w_hit;
            a_wr_en  <= wr_hs && a_hit;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs) begin
                case (awaddr)
                    lenet_mac_pkg::REG_CTRL:  exact_mode <= wdata[1];
                    lenet_mac_pkg::REG_LEN:   len <= wdata[lenet_mac_pkg::LEN_W-1:0];
                    lenet_mac_pkg::REG_SHIFT: shift <= wdata[lenet_mac_pkg::SHIFT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            wr_addr <= w_hit ? w_off[lenet_mac_pkg::ADDR_W+1:2]
                             : a_off[lenet_mac_pkg::ADDR_W+1:2];
            wr_data <= wdata[lenet_mac_pkg::DATA_W-1:0];
            bresp   <= (reg_hit(awaddr) || w_hit || a_hit) ? lenet_mac_pkg::RESP_OKAY
                                                           : lenet_mac_pkg::RESP_SLVERR;
        end
        if (rd_hs) begin
            rdata <= rd_mux;
            rresp <= reg_hit(araddr) ? lenet_mac_pkg::RESP_OKAY : lenet_mac_pkg::RESP_SLVERR;
        end
    end

    // ##########################################################
    // read channel
    // ##########################################################
    always_comb begin
        rd_mux = '0;
        case (araddr)
            lenet_mac_pkg::REG_CTRL:   rd_mux[1] = exact_mode;
            lenet_mac_pkg::REG_STATUS: rd_mux[1:0] = {done, busy};
            lenet_mac_pkg::REG_LEN:    rd_mux[lenet_mac_pkg::LEN_W-1:0] = len;
            lenet_mac_pkg::REG_SHIFT:  rd_mux[lenet_mac_pkg::SHIFT_W-1:0] = shift;
            lenet_mac_pkg::REG_RESULT: rd_mux[lenet_mac_pkg::DATA_W-1:0] = result;
            lenet_mac_pkg::REG_ACC:    rd_mux[lenet_mac_pkg::ACC_W-1:0] = acc;
            default:                   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ##########################################################
    // tap sequencer
    // ##########################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            issue      <= 1'b0;
            rd_addr    <= '0;
            acc_clear  <= 1'b0;
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            acc_clear  <= start_go;
            valid_pipe <= {valid_pipe[0], issue};
            last_pipe  <= {last_pipe[0], issue_last};
            if (start_go) begin
                busy    <= 1'b1;
                done    <= 1'b0;
                issue   <= 1'b1;
                rd_addr <= '0;
            end else begin
                if (issue_last) begin
                    issue <= 1'b0;
                end else if (issue) begin
                    rd_addr <= rd_addr + 1'b1;
                end
                if (acc_done) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // ram read plus product register.
    assign tap_valid = valid_pipe[1];
    assign last_tap  = last_pipe[1];

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

    a_tap_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        tap_valid |-> busy);

endmodule

`default_nettype wire

// ==== logic/operand_ram.sv ====
`default_nettype none

module operand_ram (
    input  wire                              clk,
    input  wire                              wr_en,
    input  wire  [lenet_mac_pkg::ADDR_W-1:0] wr_addr,
    input  wire  [lenet_mac_pkg::DATA_W-1:0] wr_data,
    input  wire  [lenet_mac_pkg::ADDR_W-1:0] rd_addr,
    output logic [lenet_mac_pkg::DATA_W-1:0] rd_data
);

    logic [lenet_mac_pkg::DATA_W-1:0] mem [lenet_mac_pkg::TAPS_MAX];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data lands one cycle after the address.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire
